//--- divider.f
hw/div_pkg.sv
hw/div_stage_reg.sv
hw/div_operand_prep.sv
hw/div_nonrestoring_core.sv
hw/div_result_issue.sv
hw/div_unit.sv
dv/tb_clk_gen.sv
dv/div_unit_tb.sv

//--- Bender.yml
package:
  name: divider

sources:
  - files:
      - hw/div_pkg.sv
      - hw/div_stage_reg.sv
      - hw/div_operand_prep.sv
      - hw/div_nonrestoring_core.sv
      - hw/div_result_issue.sv
      - hw/div_unit.sv

  - target: test
    files:
      - dv/tb_clk_gen.sv
      - dv/div_unit_tb.sv

//--- dv/div_unit_tb.sv
`timescale 1ns/1ps

module div_unit_tb;

    typedef logic [div_pkg::DIV_XLEN-1:0]   word_t;
    typedef logic [div_pkg::DIV_CRED_W-1:0] cred_t;

    // Requests summed over all tests
    localparam int    N_REQ   = 123;
    localparam int    MAX_CYC = N_REQ * (div_pkg::DIV_XLEN + 10) + 200;
    localparam word_t MIN_NEG = {1'b1, {(div_pkg::DIV_XLEN-1){1'b0}}};
    localparam word_t UA [6]  = '{100, 7, 32'hFFFF_FFFF, 12345, 32'hFFFF_FFFF, 32'h8000_0000};
    localparam word_t UB [6]  = '{7, 100, 1, 1, 16, 3};
    localparam word_t SA [4]  = '{32'd17, -32'd17, 32'd17, -32'd17};
    localparam word_t SB [4]  = '{32'd5, 32'd5, -32'd5, -32'd5};

    logic               clk;
    logic               resetn;
    div_pkg::div_req_t  req_i;
    logic               req_valid_i;
    logic               req_ready_o;
    logic               credit_i;
    logic               res_valid_o;
    word_t              res_data_o;

    word_t  exp_q[$];
    integer seed         = 88668;
    int     cycles       = 0;
    int     results_seen = 0;
    int     owed         = 0;
    bit     credits_on   = 1'b1;

    tb_clk_gen clk_gen0 (
        .clk_o   (clk),
        .resetn_o(resetn)
    );

    div_unit dut0 (
        .clk        (clk),
        .resetn     (resetn),
        .req_i      (req_i),
        .req_valid_i(req_valid_i),
        .req_ready_o(req_ready_o),
        .credit_i   (credit_i),
        .res_valid_o(res_valid_o),
        .res_data_o (res_data_o)
    );

    // **************************************************************************
    // Reference model and compare tasks
    // **************************************************************************

    function automatic word_t ref_result(div_pkg::div_func_e func, word_t a, word_t b);
        logic  signed_op;
        logic  rem_op;
        word_t res;
        signed_op = (func == div_pkg::DIV) || (func == div_pkg::REM);
        rem_op    = (func == div_pkg::REM) || (func == div_pkg::REMU);
        if (b == '0) begin
            res = rem_op ? a : '1;
        end else if (signed_op && (a == MIN_NEG) && (b == '1)) begin
            res = rem_op ? '0 : a;
        end else if (signed_op) begin
            res = rem_op ? $signed(a) % $signed(b) : $signed(a) / $signed(b);
        end else begin
            res = rem_op ? a % b : a / b;
        end
        return res;
    endfunction

    task automatic check_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    task automatic check_count(input string name, input cred_t got, input cred_t exp);
        if (got !== exp) begin
            $display("ERROR %0t %s got %0d expected %0d", $time, name, got, exp);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    // **************************************************************************
    // Drivers, credit return, monitor and timeout
    // **************************************************************************

    task automatic send_req(input div_pkg::div_func_e func, input word_t a, input word_t b);
        div_pkg::div_req_t req;
        req.func     = func;
        req.dividend = a;
        req.divisor  = b;
        @(posedge clk);
        req_i       <= req;
        req_valid_i <= 1'b1;
        @(negedge clk);
        while (!req_ready_o) @(negedge clk);
        exp_q.push_back(ref_result(func, a, b));
    endtask

    task automatic release_req();
        @(posedge clk);
        req_valid_i <= 1'b0;
    endtask

    // The last credit goes back one cycle after the last result
    task automatic drain();
        do @(posedge clk); while (exp_q.size() != 0);
        repeat (2) @(posedge clk);
    endtask

    always @(posedge clk) begin
        if (credits_on && owed > 0) begin
            credit_i <= 1'b1;
            owed = owed - 1;
        end else begin
            credit_i <= 1'b0;
        end
    end

    always @(negedge clk) begin
        if (resetn && res_valid_o) begin
            if (exp_q.size() == 0) begin
                $display("Result %h at %0t arrived with no request outstanding",
                         res_data_o, $time);
                $display("TB FAILED");
                $fatal(1);
            end else begin
                check_word("res_data_o", res_data_o, exp_q.pop_front());
                results_seen = results_seen + 1;
                owed = owed + 1;
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= MAX_CYC) begin
            $display("Timeout after %0d cycles with %0d results outstanding",
                     cycles, exp_q.size());
            $display("TB FAILED");
            $fatal(1);
        end
    end

    // **************************************************************************
    // Directed tests
    // **************************************************************************

    task automatic test_unsigned();
        word_t a;
        word_t b;
        for (int i = 0; i < 6; i++) begin
            send_req(div_pkg::DIVU, UA[i], UB[i]);
            send_req(div_pkg::REMU, UA[i], UB[i]);
        end
        for (int i = 0; i < 20; i++) begin
            a = $random(seed);
            b = $random(seed);
            b = (b >> b[4:0]) | word_t'(1);
            send_req(div_pkg::DIVU, a, b);
            send_req(div_pkg::REMU, a, b);
        end
        release_req();
        drain();
    endtask

    task automatic test_signed();
        word_t a;
        word_t b;
        for (int i = 0; i < 4; i++) begin
            send_req(div_pkg::DIV, SA[i], SB[i]);
            send_req(div_pkg::REM, SA[i], SB[i]);
        end
        for (int i = 0; i < 10; i++) begin
            a = $random(seed);
            b = $random(seed);
            b = word_t'($signed(b) >>> b[4:0]) | word_t'(1);
            send_req(div_pkg::DIV, a, b);
            send_req(div_pkg::REM, a, b);
        end
        release_req();
        drain();
    endtask

    task automatic test_special();
        send_req(div_pkg::DIV, 32'hFFFF_FFF9, '0);
        send_req(div_pkg::DIVU, 32'h1234_5678, '0);
        send_req(div_pkg::REM, 32'hFFFF_FFF9, '0);
        send_req(div_pkg::REMU, 32'h1234_5678, '0);
        send_req(div_pkg::DIV, MIN_NEG, '1);
        send_req(div_pkg::REM, MIN_NEG, '1);
        send_req(div_pkg::DIVU, MIN_NEG, '1);
        send_req(div_pkg::REMU, MIN_NEG, '1);
        release_req();
        drain();
    endtask

    task automatic test_backpressure();
        int base;
        @(negedge clk);
        credits_on = 1'b0;
        base = results_seen;
        for (int i = 0; i < 5; i++) begin
            send_req(div_pkg::DIVU, word_t'(1000 + 37 * i), word_t'(7 + i));
        end
        release_req();
        @(negedge clk);
        while (req_ready_o) @(negedge clk);
        // Long enough for the core to finish its job and hold it
        repeat (2 * (div_pkg::DIV_XLEN + 10)) @(negedge clk);
        if (req_ready_o) begin
            $display("req_ready_o rose at %0t while all credits were withheld", $time);
            $display("TB FAILED");
            $fatal(1);
        end
        check_count("results_seen", cred_t'(results_seen - base), cred_t'(div_pkg::DIV_CREDITS));
        credits_on = 1'b1;
        drain();
    endtask

    task automatic test_stream();
        word_t              a;
        word_t              b;
        word_t              r;
        div_pkg::div_func_e f;
        for (int i = 0; i < 30; i++) begin
            r = $random(seed);
            f = div_pkg::div_func_e'(r[1:0]);
            a = $random(seed);
            b = $random(seed);
            b = b >> r[6:2];
            if (i % 5 == 2) begin
                b = '0;
            end else if (i % 7 == 3) begin
                a = MIN_NEG;
                b = '1;
            end
            send_req(f, a, b);
        end
        release_req();
        drain();
    endtask

    initial begin
        req_i       = '0;
        req_valid_i = 1'b0;
        credit_i    = 1'b0;
        wait (resetn === 1'b1);
        test_unsigned();
        test_signed();
        test_special();
        test_backpressure();
        test_stream();
        $display("TB PASSED");
        $finish;
    end

endmodule

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS    = 4,
    parameter int RESET_CYCLES = 3
) (
    output logic clk_o,
    output logic resetn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2.0) clk_o = ~clk_o;
    end

    initial begin
        resetn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        resetn_o <= 1'b1;
    end

endmodule

//--- hw/div_unit.sv
`timescale 1ns/1ps

module div_unit (
    input  logic                            clk,
    input  logic                            resetn,

    input  div_pkg::div_req_t               req_i,
    input  logic                            req_valid_i,
    output logic                            req_ready_o,

    input  logic                            credit_i,
    output logic                            res_valid_o,
    output logic [div_pkg::DIV_XLEN-1:0]    res_data_o
);

    div_pkg::div_job_t  job_d;
    div_pkg::div_job_t  job_q;
    logic               job_valid;
    logic               job_ready;

    div_pkg::div_raw_t  raw;
    logic               raw_valid;
    logic               raw_ready;

    div_operand_prep u_prep (
        .req_i  (req_i),
        .job_o  (job_d)
    );

    // Stage register A sits between operand prep and the core
    div_stage_reg #(
        .payload_t  (div_pkg::div_job_t)
    ) u_reg_a (
        .clk        (clk),
        .resetn     (resetn),
        .in_i       (job_d),
        .in_valid_i (req_valid_i),
        .in_ready_o (req_ready_o),
        .out_o      (job_q),
        .out_valid_o(job_valid),
        .out_ready_i(job_ready)
    );

    div_nonrestoring_core u_core (
        .clk        (clk),
        .resetn     (resetn),
        .job_i      (job_q),
        .job_valid_i(job_valid),
        .job_ready_o(job_ready),
        .raw_o      (raw),
        .raw_valid_o(raw_valid),
        .raw_ready_i(raw_ready)
    );

    div_result_issue u_issue (
        .clk        (clk),
        .resetn     (resetn),
        .raw_i      (raw),
        .raw_valid_i(raw_valid),
        .raw_ready_o(raw_ready),
        .credit_i   (credit_i),
        .res_valid_o(res_valid_o),
        .res_data_o (res_data_o)
    );

endmodule

//--- hw/div_result_issue.sv
`timescale 1ns/1ps

module div_result_issue (
    input  logic                            clk,
    input  logic                            resetn,

    input  div_pkg::div_raw_t               raw_i,
    input  logic                            raw_valid_i,
    output logic                            raw_ready_o,

    input  logic                            credit_i,
    output logic                            res_valid_o,
    output logic [div_pkg::DIV_XLEN-1:0]    res_data_o
);

    logic [div_pkg::DIV_XLEN-1:0]   qnt_fix;
    logic [div_pkg::DIV_XLEN-1:0]   rem_fix;
    logic [div_pkg::DIV_XLEN-1:0]   res_d;
    logic                           res_held;
    logic                           credit_ok;
    logic [div_pkg::DIV_CRED_W-1:0] cnt_q;

    // Restore the signs dropped by operand prep
    assign qnt_fix = raw_i.neg_qnt ? (~raw_i.quotient + 1'b1) : raw_i.quotient;
    assign rem_fix = raw_i.neg_rem ? (~raw_i.remainder + 1'b1) : raw_i.remainder;

    always_comb begin
        if (raw_i.special) begin
            res_d = raw_i.special_res;
        end else if (raw_i.rem_op) begin
            res_d = rem_fix;
        end else begin
            res_d = qnt_fix;
        end
    end

    div_stage_reg #(
        .payload_t  (logic [div_pkg::DIV_XLEN-1:0])
    ) u_res_reg (
        .clk        (clk),
        .resetn     (resetn),
        .in_i       (res_d),
        .in_valid_i (raw_valid_i),
        .in_ready_o (raw_ready_o),
        .out_o      (res_data_o),
        .out_valid_o(res_held),
        .out_ready_i(credit_ok)
    );

    // **************************************************************************
    // Credit counter
    // **************************************************************************

    assign credit_ok   = (cnt_q != '0);
    assign res_valid_o = res_held & credit_ok;

    always_ff @(posedge clk or negedge resetn) begin
        if (~resetn) begin
            cnt_q <= div_pkg::DIV_CRED_W'(div_pkg::DIV_CREDITS);
        end else if (res_valid_o & ~credit_i) begin
            cnt_q <= cnt_q - 1'b1;
        end else if (credit_i & ~res_valid_o) begin
            cnt_q <= cnt_q + 1'b1;
        end
    end

    a_no_excess_credit: assert property (@(posedge clk) disable iff (~resetn)
        credit_i |-> (cnt_q < div_pkg::DIV_CRED_W'(div_pkg::DIV_CREDITS)));

endmodule

//--- hw/div_nonrestoring_core.sv
`timescale 1ns/1ps

module div_nonrestoring_core (
    input  logic                clk,
    input  logic                resetn,

    input  div_pkg::div_job_t   job_i,
    input  logic                job_valid_i,
    output logic                job_ready_o,

    output div_pkg::div_raw_t   raw_o,
    output logic                raw_valid_o,
    input  logic                raw_ready_i
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_CORRECT,
        S_DONE
    } core_state_e;

    core_state_e                        state_q;
    logic [div_pkg::DIV_CNT_W-1:0]      count_q;

    logic [div_pkg::DIV_XLEN:0]         prem_q;
    logic [div_pkg::DIV_XLEN:0]         prem_shift;
    logic [div_pkg::DIV_XLEN:0]         prem_step;
    logic [div_pkg::DIV_XLEN-1:0]       qnt_q;
    logic [div_pkg::DIV_XLEN-1:0]       dvs_q;
    logic [div_pkg::DIV_XLEN-1:0]       special_res_q;
    logic                               rem_op_q;
    logic                               neg_qnt_q;
    logic                               neg_rem_q;
    logic                               special_q;
    logic                               load;

    assign job_ready_o = (state_q == S_IDLE);
    assign raw_valid_o = (state_q == S_DONE);
    assign load        = job_valid_i & job_ready_o;

    // One non-restoring step: shift in the next dividend bit, then add or
    // subtract the divisor depending on the sign of the partial remainder
    always_comb begin
        prem_shift = {prem_q[div_pkg::DIV_XLEN-1:0], qnt_q[div_pkg::DIV_XLEN-1]};
        if (prem_q[div_pkg::DIV_XLEN]) begin
            prem_step = prem_shift + {1'b0, dvs_q};
        end else begin
            prem_step = prem_shift - {1'b0, dvs_q};
        end
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (~resetn) begin
            state_q <= S_IDLE;
            count_q <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (job_valid_i) begin
                        count_q <= '0;
                        state_q <= job_i.special ? S_DONE : S_RUN;
                    end
                end
                S_RUN: begin
                    count_q <= count_q + 1'b1;
                    if (count_q == div_pkg::DIV_CNT_W'(div_pkg::DIV_XLEN - 1)) begin
                        state_q <= S_CORRECT;
                    end
                end
                S_CORRECT: begin
                    state_q <= S_DONE;
                end
                S_DONE: begin
                    if (raw_ready_i) begin
                        state_q <= S_IDLE;
                    end
                end
                default: begin
                    state_q <= S_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            prem_q        <= '0;
            qnt_q         <= job_i.dividend_abs;
            dvs_q         <= job_i.divisor_abs;
            rem_op_q      <= job_i.rem_op;
            neg_qnt_q     <= job_i.neg_qnt;
            neg_rem_q     <= job_i.neg_rem;
            special_q     <= job_i.special;
            special_res_q <= job_i.special_res;
        end else if (state_q == S_RUN) begin
            prem_q <= prem_step;
            qnt_q  <= {qnt_q[div_pkg::DIV_XLEN-2:0], ~prem_step[div_pkg::DIV_XLEN]};
        end else if ((state_q == S_CORRECT) & prem_q[div_pkg::DIV_XLEN]) begin
            prem_q <= prem_q + {1'b0, dvs_q};
        end
    end

    always_comb begin
        raw_o.quotient    = qnt_q;
        raw_o.remainder   = prem_q[div_pkg::DIV_XLEN-1:0];
        raw_o.rem_op      = rem_op_q;
        raw_o.neg_qnt     = neg_qnt_q;
        raw_o.neg_rem     = neg_rem_q;
        raw_o.special     = special_q;
        raw_o.special_res = special_res_q;
    end

    a_count_range: assert property (@(posedge clk) disable iff (~resetn)
        (state_q == S_RUN) |-> (count_q < div_pkg::DIV_CNT_W'(div_pkg::DIV_XLEN)));

    a_rem_below_dvs: assert property (@(posedge clk) disable iff (~resetn)
        ((state_q == S_DONE) & ~special_q) |->
            (~prem_q[div_pkg::DIV_XLEN] & (prem_q[div_pkg::DIV_XLEN-1:0] < dvs_q)));

endmodule

//--- hw/div_operand_prep.sv
`timescale 1ns/1ps

module div_operand_prep (
    input  div_pkg::div_req_t   req_i,
    output div_pkg::div_job_t   job_o
);

    logic                           signed_op;
    logic                           rem_op;
    logic                           dividend_neg;
    logic                           divisor_neg;
    logic                           div_zero;
    logic                           overflow;
    logic [div_pkg::DIV_XLEN-1:0]   special_res;

    // **************************************************************************
    // Decode and special cases
    // **************************************************************************

    assign signed_op = (req_i.func == div_pkg::DIV) | (req_i.func == div_pkg::REM);
    assign rem_op    = (req_i.func == div_pkg::REM) | (req_i.func == div_pkg::REMU);

    assign dividend_neg = signed_op & req_i.dividend[div_pkg::DIV_XLEN-1];
    assign divisor_neg  = signed_op & req_i.divisor[div_pkg::DIV_XLEN-1];

    assign div_zero = (req_i.divisor == '0);

    // Most negative value over minus one does not fit
    assign overflow = signed_op
                    & (req_i.dividend == {1'b1, {(div_pkg::DIV_XLEN-1){1'b0}}})
                    & (req_i.divisor == '1);

    always_comb begin
        if (div_zero) begin
            special_res = rem_op ? req_i.dividend : '1;
        end else if (overflow) begin
            special_res = rem_op ? '0 : req_i.dividend;
        end else begin
            special_res = '0;
        end
    end

    // **************************************************************************
    // Magnitudes and sign correction flags
    // **************************************************************************

    always_comb begin
        job_o.dividend_abs = dividend_neg ? (~req_i.dividend + 1'b1) : req_i.dividend;
        job_o.divisor_abs  = divisor_neg ? (~req_i.divisor + 1'b1) : req_i.divisor;
        job_o.rem_op       = rem_op;
        job_o.neg_qnt      = dividend_neg ^ divisor_neg;
        job_o.neg_rem      = dividend_neg;
        job_o.special      = div_zero | overflow;
        job_o.special_res  = special_res;
    end

endmodule

//--- hw/div_stage_reg.sv
`timescale 1ns/1ps

module div_stage_reg #(
    parameter type payload_t = logic
) (
    input  logic        clk,
    input  logic        resetn,

    input  payload_t    in_i,
    input  logic        in_valid_i,
    output logic        in_ready_o,

    output payload_t    out_o,
    output logic        out_valid_o,
    input  logic        out_ready_i
);

    logic       valid_q;
    payload_t   data_q;

    // Room is free when empty or when the held entry leaves this cycle
    assign in_ready_o  = ~valid_q | out_ready_i;
    assign out_valid_o = valid_q;
    assign out_o       = data_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (~resetn) begin
            valid_q <= 1'b0;
        end else if (in_ready_o) begin
            valid_q <= in_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid_i & in_ready_o) begin
            data_q <= in_i;
        end
    end

    a_hold_stable: assert property (@(posedge clk) disable iff (~resetn)
        (out_valid_o & ~out_ready_i) |=> (out_valid_o & $stable(out_o)));

endmodule

//--- hw/div_pkg.sv
package div_pkg;

    localparam int DIV_XLEN    = 32;
    localparam int DIV_CNT_W   = 6;
    localparam int DIV_CREDITS = 2;
    localparam int DIV_CRED_W  = $clog2(DIV_CREDITS + 1);

    typedef enum logic [1:0] {
        DIV  = 2'b00,
        DIVU = 2'b01,
        REM  = 2'b10,
        REMU = 2'b11
    } div_func_e;

    typedef struct packed {
        div_func_e              func;
        logic [DIV_XLEN-1:0]    dividend;
        logic [DIV_XLEN-1:0]    divisor;
    } div_req_t;

    // Work handed to the iteration core, operands already made positive
    typedef struct packed {
        logic [DIV_XLEN-1:0]    dividend_abs;
        logic [DIV_XLEN-1:0]    divisor_abs;
        logic                   rem_op;
        logic                   neg_qnt;
        logic                   neg_rem;
        logic                   special;
        logic [DIV_XLEN-1:0]    special_res;
    } div_job_t;

    typedef struct packed {
        logic [DIV_XLEN-1:0]    quotient;
        logic [DIV_XLEN-1:0]    remainder;
        logic                   rem_op;
        logic                   neg_qnt;
        logic                   neg_rem;
        logic                   special;
        logic [DIV_XLEN-1:0]    special_res;
    } div_raw_t;

endpackage
